// ==== design/phaseSequencer.sv ====
`timescale 1ns/10ps

module phaseSequencer (
	input  logic              CLOCK,
	input  logic              arstN,
	input  logic              sensorMode,
	input  logic              emergency,
	input  logic [7:0]        greenMaj,
	input  logic [7:0]        greenMin,
	input  logic [7:0]        yellow,
	input  logic [7:0]        allRed,
	input  logic              requestPending,
	output trafficPkg::phaseT phase,
	output logic [7:0]        secondsLeft,  // Whole seconds after the current one
	output logic              tick
);

	logic [trafficPkg::TICK_W-1:0] tickCnt;  // Prescaler
	logic [7:0] secCnt;
	logic       emergQ;     // Emergency last cycle
	logic       recoverQ;   // Leave allRed1 to majGreen, after reset or emergency
	logic       emergEdge;  // Emergency just set or released
	logic       expired;    // Last second of the phase is over
	logic       hold;       // Sensor mode waiting for a request
	logic       leave;
	trafficPkg::phaseT nextPhase;
	logic [7:0] nextDur;

	assign emergEdge = emergency ^ emergQ;

	// Tick suppressed on the cycle the prescaler restarts for emergency
	assign tick = (tickCnt == trafficPkg::TICK_LAST) && !emergEdge;

	assign expired = tick && (secCnt == 8'd0);
	assign hold    = (phase == trafficPkg::majGreen) && sensorMode && !requestPending;
	assign leave   = expired && !hold;

	always_comb begin
		case (phase)
			trafficPkg::majGreen:  nextPhase = trafficPkg::majYellow;
			trafficPkg::majYellow: nextPhase = trafficPkg::allRed1;
			// Restart goes back to the major street first
			trafficPkg::allRed1:   nextPhase = recoverQ ? trafficPkg::majGreen
			                                            : trafficPkg::minGreen;
			trafficPkg::minGreen:  nextPhase = trafficPkg::minYellow;
			trafficPkg::minYellow: nextPhase = trafficPkg::allRed2;
			trafficPkg::allRed2:   nextPhase = trafficPkg::majGreen;
			default:               nextPhase = trafficPkg::allRed1;  // Unused codes
		endcase
	end

	// Duration of the phase about to be entered
	always_comb begin
		case (nextPhase)
			trafficPkg::majGreen:  nextDur = greenMaj;
			trafficPkg::minGreen:  nextDur = greenMin;
			trafficPkg::majYellow,
			trafficPkg::minYellow: nextDur = yellow;
			default:               nextDur = allRed;
		endcase
	end

	always_ff @(posedge CLOCK or negedge arstN) begin
		if (!arstN) begin
			tickCnt <= '0;
			emergQ  <= 1'b0;
		end else begin
			emergQ <= emergency;
			// Wraps on every tick, phase entry always lines up with a wrap
			if (tick || emergEdge)
				tickCnt <= '0;
			else
				tickCnt <= tickCnt + 1'b1;
		end
	end

	always_ff @(posedge CLOCK or negedge arstN) begin
		if (!arstN) begin
			phase    <= trafficPkg::allRed1;
			secCnt   <= trafficPkg::DEF_ALL_RED - 8'd1;
			recoverQ <= 1'b1;
		end else if (emergency) begin
			// Frozen in allRed1, count kept full
			phase    <= trafficPkg::allRed1;
			secCnt   <= allRed - 8'd1;
			recoverQ <= 1'b1;
		end else if (emergEdge) begin
			secCnt <= allRed - 8'd1;  // Release, allRed1 starts over
		end else if (leave) begin
			phase  <= nextPhase;
			secCnt <= nextDur - 8'd1;  // Durations are never zero
			if (phase == trafficPkg::allRed1)
				recoverQ <= 1'b0;
		end else if (tick && (secCnt != 8'd0)) begin
			secCnt <= secCnt - 8'd1;
		end
	end

	assign secondsLeft = secCnt;

endmodule

// ==== design/requestLatch.sv ====
`timescale 1ns/10ps

module requestLatch (
	input  logic              CLOCK,
	input  logic              arstN,
	input  logic              walkButton,  // Asynchronous
	input  logic              carSensor,   // Asynchronous
	input  trafficPkg::phaseT phase,
	output logic              requestPending
);

	logic walkS1, walkS2;  // Button synchronizer
	logic carS1, carS2;    // Sensor synchronizer
	logic minGreenQ;       // Phase was minGreen last cycle
	logic clearReq;

	always_ff @(posedge CLOCK or negedge arstN) begin
		if (!arstN) begin
			walkS1 <= 1'b0;
			walkS2 <= 1'b0;
			carS1  <= 1'b0;
			carS2  <= 1'b0;
		end else begin
			walkS1 <= walkButton;
			walkS2 <= walkS1;
			carS1  <= carSensor;
			carS2  <= carS1;
		end
	end

	// Clear only on minGreen entry, later presses stay latched
	assign clearReq = (phase == trafficPkg::minGreen) && !minGreenQ;

	always_ff @(posedge CLOCK or negedge arstN) begin
		if (!arstN) begin
			minGreenQ      <= 1'b0;
			requestPending <= 1'b0;
		end else begin
			minGreenQ <= (phase == trafficPkg::minGreen);
			if (clearReq)
				requestPending <= 1'b0;  // Served by this minor green
			else if (walkS2 || carS2)
				requestPending <= 1'b1;  // Sticky
		end
	end

endmodule

// ==== design/signalHeads.sv ====
`timescale 1ns/10ps

module signalHeads (
	input  logic              CLOCK,
	input  logic              arstN,
	input  trafficPkg::phaseT phase,
	input  logic [7:0]        secondsLeft,
	input  logic              tick,
	input  logic              emergency,
	output logic [2:0]        lampMaj,  // {red, yellow, green}
	output logic [2:0]        lampMin,
	output logic              walkMaj,
	output logic              dontWalkMaj,
	output logic              walkMin,
	output logic              dontWalkMin,
	output logic [6:0]        segMaj,   // {g,f,e,d,c,b,a}
	output logic [6:0]        segMin
);

	logic       blinkQ;    // Emergency red state
	logic [3:0] digit;     // Countdown clipped to one digit
	logic [6:0] digitSeg;

	function automatic logic [6:0] segOf(input logic [3:0] d);
		case (d)
			4'd0:    segOf = 7'b011_1111;
			4'd1:    segOf = 7'b000_0110;
			4'd2:    segOf = 7'b101_1011;
			4'd3:    segOf = 7'b100_1111;
			4'd4:    segOf = 7'b110_0110;
			4'd5:    segOf = 7'b110_1101;
			4'd6:    segOf = 7'b111_1101;
			4'd7:    segOf = 7'b000_0111;
			4'd8:    segOf = 7'b111_1111;
			4'd9:    segOf = 7'b110_1111;
			default: segOf = trafficPkg::SEG_BLANK;
		endcase
	endfunction

	// Reds start lit when emergency begins, then toggle each second
	always_ff @(posedge CLOCK or negedge arstN) begin
		if (!arstN)
			blinkQ <= 1'b1;
		else if (!emergency)
			blinkQ <= 1'b1;
		else if (tick)
			blinkQ <= ~blinkQ;
	end

	assign digit    = (secondsLeft > 8'd9) ? 4'd9 : secondsLeft[3:0];
	assign digitSeg = segOf(digit);

	always_comb begin
		lampMaj = 3'b100;  // Red unless the phase says otherwise
		lampMin = 3'b100;
		walkMaj = 1'b0;
		walkMin = 1'b0;
		segMaj  = trafficPkg::SEG_BLANK;
		segMin  = trafficPkg::SEG_BLANK;
		case (phase)
			trafficPkg::majGreen: begin
				lampMaj = 3'b001;
				walkMin = 1'b1;      // Minor crosswalk crosses stopped minor street
				segMin  = digitSeg;
			end
			trafficPkg::majYellow: lampMaj = 3'b010;
			trafficPkg::minGreen: begin
				lampMin = 3'b001;
				walkMaj = 1'b1;
				segMaj  = digitSeg;
			end
			trafficPkg::minYellow: lampMin = 3'b010;
			default: ; // All red
		endcase
		if (emergency) begin
			lampMaj = {blinkQ, 2'b00};
			lampMin = {blinkQ, 2'b00};
			walkMaj = 1'b0;
			walkMin = 1'b0;
			segMaj  = trafficPkg::SEG_BLANK;
			segMin  = trafficPkg::SEG_BLANK;
		end
	end

	assign dontWalkMaj = ~walkMaj;
	assign dontWalkMin = ~walkMin;

endmodule

// ==== design/timingRegs.sv ====
`timescale 1ns/10ps

module timingRegs (
	input  logic               CLOCK,
	input  logic               arstN,
	input  logic               cyc,
	input  logic               stb,
	input  logic               we,
	input  logic [2:0]         adr,
	input  logic [31:0]        datW,
	input  logic               requestPending,
	input  trafficPkg::phaseT  phase,
	output logic               ack,
	output logic [31:0]        datR,
	output logic               sensorMode,
	output logic               emergency,
	output logic [7:0]         greenMaj,
	output logic [7:0]         greenMin,
	output logic [7:0]         yellow,
	output logic [7:0]         allRed
);

	logic [1:0] ctrlQ;   // {emergency, sensor}
	logic       access;  // Cycle that raises ack
	logic [7:0] durIn;   // Written duration, never zero
	logic [31:0] readMux;

	// New access only when ack is low, so ack never stays up two cycles
	assign access = cyc & stb & ~ack;

	// Zero length phase not allowed, store as one second
	assign durIn = (datW[7:0] == 8'd0) ? 8'd1 : datW[7:0];

	always_ff @(posedge CLOCK or negedge arstN) begin
		if (!arstN) begin
			ack <= 1'b0;
		end else begin
			ack <= access;
		end
	end

	// Writes land on the edge that raises ack
	always_ff @(posedge CLOCK or negedge arstN) begin
		if (!arstN) begin
			ctrlQ    <= 2'b00;  // Timer mode, no emergency
			greenMaj <= trafficPkg::DEF_GREEN_MAJ;
			greenMin <= trafficPkg::DEF_GREEN_MIN;
			yellow   <= trafficPkg::DEF_YELLOW;
			allRed   <= trafficPkg::DEF_ALL_RED;
		end else if (access && we) begin
			case (adr)
				trafficPkg::ADDR_CTRL:      ctrlQ    <= datW[1:0];
				trafficPkg::ADDR_GREEN_MAJ: greenMaj <= durIn;
				trafficPkg::ADDR_GREEN_MIN: greenMin <= durIn;
				trafficPkg::ADDR_YELLOW:    yellow   <= durIn;
				trafficPkg::ADDR_ALL_RED:   allRed   <= durIn;
				default: ; // STATUS and holes ignore writes
			endcase
		end
	end

	assign sensorMode = ctrlQ[trafficPkg::CTRL_SENSOR];
	assign emergency  = ctrlQ[trafficPkg::CTRL_EMERG];

	// Address held by master until ack, so a plain mux is enough
	always_comb begin
		case (adr)
			trafficPkg::ADDR_CTRL:      readMux = {30'd0, ctrlQ};
			trafficPkg::ADDR_GREEN_MAJ: readMux = {24'd0, greenMaj};
			trafficPkg::ADDR_GREEN_MIN: readMux = {24'd0, greenMin};
			trafficPkg::ADDR_YELLOW:    readMux = {24'd0, yellow};
			trafficPkg::ADDR_ALL_RED:   readMux = {24'd0, allRed};
			// Bits 2:0 live phase, bit 3 pending request
			trafficPkg::ADDR_STATUS:    readMux = {28'd0, requestPending, phase};
			default:                    readMux = 32'd0;
		endcase
	end

	assign datR = readMux;

endmodule

// ==== design/trafficController.sv ====
`timescale 1ns/10ps

module trafficController (
	input  logic        CLOCK,
	input  logic        arstN,
	input  logic        cyc,         // Wishbone classic slave
	input  logic        stb,
	input  logic        we,
	input  logic [2:0]  adr,
	input  logic [31:0] datW,
	output logic        ack,
	output logic [31:0] datR,
	input  logic        walkButton,
	input  logic        carSensor,
	output logic [2:0]  lampMaj,
	output logic [2:0]  lampMin,
	output logic        walkMaj,
	output logic        dontWalkMaj,
	output logic        walkMin,
	output logic        dontWalkMin,
	output logic [6:0]  segMaj,
	output logic [6:0]  segMin
);

	logic              sensorMode;
	logic              emergency;
	logic [7:0]        greenMaj;
	logic [7:0]        greenMin;
	logic [7:0]        yellow;
	logic [7:0]        allRed;
	logic              requestPending;
	trafficPkg::phaseT phase;
	logic [7:0]        secondsLeft;
	logic              tick;

	timingRegs i_timingRegs (
		.CLOCK(CLOCK), .arstN(arstN),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .datW(datW),
		.requestPending(requestPending), .phase(phase),
		.ack(ack), .datR(datR),
		.sensorMode(sensorMode), .emergency(emergency),
		.greenMaj(greenMaj), .greenMin(greenMin), .yellow(yellow), .allRed(allRed)
	);

	requestLatch i_requestLatch (
		.CLOCK(CLOCK), .arstN(arstN),
		.walkButton(walkButton), .carSensor(carSensor),
		.phase(phase), .requestPending(requestPending)
	);

	phaseSequencer i_phaseSequencer (
		.CLOCK(CLOCK), .arstN(arstN),
		.sensorMode(sensorMode), .emergency(emergency),
		.greenMaj(greenMaj), .greenMin(greenMin), .yellow(yellow), .allRed(allRed),
		.requestPending(requestPending),
		.phase(phase), .secondsLeft(secondsLeft), .tick(tick)
	);

	signalHeads i_signalHeads (
		.CLOCK(CLOCK), .arstN(arstN),
		.phase(phase), .secondsLeft(secondsLeft), .tick(tick), .emergency(emergency),
		.lampMaj(lampMaj), .lampMin(lampMin),
		.walkMaj(walkMaj), .dontWalkMaj(dontWalkMaj),
		.walkMin(walkMin), .dontWalkMin(dontWalkMin),
		.segMaj(segMaj), .segMin(segMin)
	);

endmodule

// ==== design/trafficPkg.sv ====
package trafficPkg;

	// Phases in sequence order, allRed1 is the reset and emergency phase
	typedef enum logic [2:0] {
		majGreen  = 3'd0,
		majYellow = 3'd1,
		allRed1   = 3'd2,
		minGreen  = 3'd3,
		minYellow = 3'd4,
		allRed2   = 3'd5
	} phaseT;

	// Clock cycles per one second tick, small for simulation
	localparam int TICK_CYCLES = 4;
	localparam int TICK_W = $clog2(TICK_CYCLES);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICK_CYCLES - 1); // Last prescaler count

	// Durations after reset, in seconds
	localparam logic [7:0] DEF_GREEN_MAJ = 8'd8;
	localparam logic [7:0] DEF_GREEN_MIN = 8'd5;
	localparam logic [7:0] DEF_YELLOW    = 8'd2;
	localparam logic [7:0] DEF_ALL_RED   = 8'd1;

	// Register map, word addresses
	localparam logic [2:0] ADDR_CTRL      = 3'd0;
	localparam logic [2:0] ADDR_GREEN_MAJ = 3'd1;
	localparam logic [2:0] ADDR_GREEN_MIN = 3'd2;
	localparam logic [2:0] ADDR_YELLOW    = 3'd3;
	localparam logic [2:0] ADDR_ALL_RED   = 3'd4;
	localparam logic [2:0] ADDR_STATUS    = 3'd5; // Read only

	// Control word bits
	localparam int CTRL_SENSOR = 0; // 1 = sensor mode, 0 = timer mode
	localparam int CTRL_EMERG  = 1; // Police emergency switch

	// Segments {g,f,e,d,c,b,a}, active high
	localparam logic [6:0] SEG_BLANK = 7'b000_0000;

endpackage

// ==== sim.f ====
design/trafficPkg.sv
design/timingRegs.sv
design/requestLatch.sv
design/phaseSequencer.sv
design/signalHeads.sv
design/trafficController.sv
verif/trafficControllerProperties.sv
verif/trafficControllerTb.sv

// ==== verif/trafficControllerProperties.sv ====
`timescale 1ns/10ps

module trafficControllerProperties (
	input logic              CLOCK,
	input logic              arstN,
	input trafficPkg::phaseT phase,
	input logic              emergency,
	input logic [2:0]        lampMaj,  // {red, yellow, green}
	input logic [2:0]        lampMin,
	input logic              walkMaj,
	input logic              walkMin
);

	int failCount = 0;  // Assertion failures so far

	// Never green both ways
	greensExclusive: assert property (@(posedge CLOCK) disable iff (!arstN)
		!(lampMaj[0] && lampMin[0]))
		else begin
			$error("Both streets show green");
			failCount++;
		end

	// WALK only across a stopped street
	walkMajSafe: assert property (@(posedge CLOCK) disable iff (!arstN)
		walkMaj |-> (lampMaj[1:0] == 2'b00))
		else begin
			$error("Major WALK while major street moves");
			failCount++;
		end
	walkMinSafe: assert property (@(posedge CLOCK) disable iff (!arstN)
		walkMin |-> (lampMin[1:0] == 2'b00))
		else begin
			$error("Minor WALK while minor street moves");
			failCount++;
		end

	// Green is left only through its yellow, emergency excepted
	majYellowFollows: assert property (@(posedge CLOCK) disable iff (!arstN)
		(phase == trafficPkg::majGreen && !emergency)
		|=> (phase inside {trafficPkg::majGreen, trafficPkg::majYellow}))
		else begin
			$error("Major green left without yellow");
			failCount++;
		end
	minYellowFollows: assert property (@(posedge CLOCK) disable iff (!arstN)
		(phase == trafficPkg::minGreen && !emergency)
		|=> (phase inside {trafficPkg::minGreen, trafficPkg::minYellow}))
		else begin
			$error("Minor green left without yellow");
			failCount++;
		end

endmodule

bind signalHeads trafficControllerProperties i_props (.*);

// ==== verif/trafficControllerTb.sv ====
`timescale 1ns/10ps

module trafficControllerTb;

	localparam int LIMIT = 2000;  // Cycles any wait may take

	logic CLOCK = 1'b0, arstN, cyc, stb, we, ack, walkButton, carSensor;
	logic walkMaj, dontWalkMaj, walkMin, dontWalkMin;
	logic [2:0] adr, lampMaj, lampMin;
	logic [31:0] datW, datR;
	logic [6:0] segMaj, segMin;
	logic [31:0] lfsr = 32'h7394_a43f;
	int errs = 0, timeouts = 0, errMark = 0;

	// Reference model state
	trafficPkg::phaseT mPhase;
	logic [7:0] mLeft, mDur [1:4];  // Durations by register address
	logic [1:0] mCtrl, mSync;
	logic [trafficPkg::TICK_W-1:0] mPre;
	logic mEmergQ, mRecover, mBlink, mReq, mMinQ, mAck;

	trafficController i_dut (.*);

	always #50 CLOCK = ~CLOCK;

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);  // Galois step
		end
		return r;
	endfunction

	function automatic logic [6:0] segFor(input int d);  // {g..a}
		case (d)
			0: return 7'h3F;
			1: return 7'h06;
			2: return 7'h5B;
			3: return 7'h4F;
			4: return 7'h66;
			5: return 7'h6D;
			6: return 7'h7D;
			7: return 7'h07;
			8: return 7'h7F;
			default: return 7'h6F;
		endcase
	endfunction

	function automatic logic [7:0] durOf(input trafficPkg::phaseT p);
		case (p)
			trafficPkg::majGreen: return mDur[1];
			trafficPkg::minGreen: return mDur[2];
			trafficPkg::majYellow, trafficPkg::minYellow: return mDur[3];
			default: return mDur[4];
		endcase
	endfunction

	// Cycle model, inputs sampled before the edge
	always @(posedge CLOCK or negedge arstN) begin : model
		logic emg, emgEdge, tk, hold;
		trafficPkg::phaseT nxt;
		if (!arstN) begin
			mPhase = trafficPkg::allRed1;
			mLeft = 8'd0;
			mDur[1] = 8'd8;
			mDur[2] = 8'd5;
			mDur[3] = 8'd2;
			mDur[4] = 8'd1;
			{mCtrl, mSync, mPre} = '0;
			{mEmergQ, mReq, mMinQ, mAck} = '0;
			mRecover = 1'b1;
			mBlink = 1'b1;
		end else begin
			emg = mCtrl[1];
			emgEdge = emg ^ mEmergQ;  // Prescaler restarts on either edge
			tk = (mPre == trafficPkg::TICK_CYCLES - 1) && !emgEdge;
			hold = (mPhase == trafficPkg::majGreen) && mCtrl[0] && !mReq;
			if (mPhase == trafficPkg::minGreen && !mMinQ) mReq = 1'b0;  // Served
			else if (mSync[1]) mReq = 1'b1;
			mMinQ = (mPhase == trafficPkg::minGreen);
			mSync = {mSync[0], walkButton | carSensor};  // Two flop delay
			if (mPhase == trafficPkg::allRed1) nxt = mRecover ? trafficPkg::majGreen
				: trafficPkg::minGreen;
			else if (mPhase == trafficPkg::allRed2) nxt = trafficPkg::majGreen;
			else nxt = trafficPkg::phaseT'(mPhase + 3'd1);
			if (emg) begin
				mPhase = trafficPkg::allRed1;
				mLeft = mDur[4] - 8'd1;
				mRecover = 1'b1;
			end else if (emgEdge) begin
				mLeft = mDur[4] - 8'd1;  // Full allRed1 after release
			end else if (tk && mLeft == 0 && !hold) begin
				if (mPhase == trafficPkg::allRed1) mRecover = 1'b0;
				mPhase = nxt;
				mLeft = durOf(nxt) - 8'd1;
			end else if (tk && mLeft != 0) begin
				mLeft--;
			end
			mBlink = !emg ? 1'b1 : (tk ? !mBlink : mBlink);
			mPre = (tk || emgEdge) ? '0 : mPre + 1'b1;
			mEmergQ = emg;
			if (cyc && stb && !mAck && we) begin  // Bus write lands with ack
				if (adr == trafficPkg::ADDR_CTRL) mCtrl = datW[1:0];
				else if (adr >= 3'd1 && adr <= 3'd4)
					mDur[adr] = (datW[7:0] == 8'd0) ? 8'd1 : datW[7:0];
			end
			mAck = cyc && stb && !mAck;
		end
	end

	// Lamps and digits against the model, mid cycle
	always @(negedge CLOCK) begin : compare
		logic [2:0] eMaj, eMin;
		logic [6:0] eSegMaj, eSegMin, digit;
		logic eWalkMaj, eWalkMin;
		if (arstN) begin
			digit = segFor(mLeft > 9 ? 9 : mLeft);
			{eMaj, eMin, eWalkMaj, eWalkMin} = {3'b100, 3'b100, 2'b00};
			{eSegMaj, eSegMin} = {trafficPkg::SEG_BLANK, trafficPkg::SEG_BLANK};
			if (mCtrl[1]) {eMaj, eMin} = {mBlink, 2'b00, mBlink, 2'b00};  // Blinking reds
			else case (mPhase)
				trafficPkg::majGreen: {eMaj, eWalkMin, eSegMin} = {3'b001, 1'b1, digit};
				trafficPkg::majYellow: eMaj = 3'b010;
				trafficPkg::minGreen: {eMin, eWalkMaj, eSegMaj} = {3'b001, 1'b1, digit};
				trafficPkg::minYellow: eMin = 3'b010;
				default: ;
			endcase
			assert (i_dut.phase == mPhase && lampMaj == eMaj && lampMin == eMin
				&& walkMaj == eWalkMaj && dontWalkMaj == !eWalkMaj && walkMin == eWalkMin
				&& dontWalkMin == !eWalkMin && segMaj == eSegMaj && segMin == eSegMin)
			else begin
				errs++;
				$display("Fail %0t: phase %0d lamps %b %b seg %h %h, expected %0d %b %b %h %h",
					$time, i_dut.phase, lampMaj, lampMin, segMaj, segMin,
					mPhase, eMaj, eMin, eSegMaj, eSegMin);
			end
		end
	end

	task automatic busCycle(input logic wr, input logic [2:0] a, input logic [31:0] d,
			output logic [31:0] q);
		int n;
		@(posedge CLOCK); #1;
		{cyc, stb, we, adr, datW} = {2'b11, wr, a, d};
		n = 0;
		do begin
			@(negedge CLOCK);
			n++;
		end while (!ack && n < 20);
		if (!ack) begin
			timeouts++;
			$display("Timeout: bus access to address %0d never acknowledged", a);
		end
		q = datR;
		@(posedge CLOCK); #1;
		{cyc, stb, we} = 3'b000;
	endtask

	task automatic writeReg(input logic [2:0] a, input logic [31:0] d);
		logic [31:0] q;
		busCycle(1'b1, a, d, q);
	endtask

	task automatic checkRead(input logic [2:0] a, input logic [31:0] exp,
			input logic [31:0] mask);
		logic [31:0] q;
		busCycle(1'b0, a, 32'd0, q);
		assert ((q & mask) == (exp & mask)) else begin
			errs++;
			$display("Fail %0t: address %0d read %h, expected %h", $time, a, q & mask, exp);
		end
	endtask

	// Ends on the first negedge of a fresh entry into p
	task automatic waitEntry(input trafficPkg::phaseT p);
		int n;
		n = 0;
		while (i_dut.phase == p && n < LIMIT) begin
			@(negedge CLOCK);
			n++;
		end
		while (i_dut.phase != p && n < LIMIT) begin
			@(negedge CLOCK);
			n++;
		end
		if (n >= LIMIT) begin
			timeouts++;
			$display("Timeout: phase %s was never entered", p.name());
		end
	endtask

	// Returns at once when already in p
	task automatic reachPhase(input trafficPkg::phaseT p);
		int n;
		n = 0;
		while (i_dut.phase != p && n < LIMIT) begin
			@(negedge CLOCK);
			n++;
		end
		if (n >= LIMIT) begin
			timeouts++;
			$display("Timeout: phase %s was never reached", p.name());
		end
	endtask

	task automatic measurePhase(input trafficPkg::phaseT p, input int cycles);
		int n;
		n = 0;
		while (i_dut.phase == p && n < LIMIT) begin
			n++;
			@(negedge CLOCK);
		end
		if (n >= LIMIT) begin
			timeouts++;
			$display("Timeout: phase %s never ended", p.name());
		end
		assert (n == cycles) else begin
			errs++;
			$display("Fail %0t: %s lasted %0d cycles, expected %0d",
				$time, p.name(), n, cycles);
		end
	endtask

	// Digit from time spent in the phase
	task automatic countdown(input trafficPkg::phaseT p, input int dur);
		int k, left;
		logic [6:0] act, idle;
		k = 0;
		while (i_dut.phase == p && k < LIMIT) begin
			left = dur - 1 - k / trafficPkg::TICK_CYCLES;
			act = (p == trafficPkg::majGreen) ? segMin : segMaj;
			idle = (p == trafficPkg::majGreen) ? segMaj : segMin;
			assert (act == segFor(left > 9 ? 9 : left) && idle == trafficPkg::SEG_BLANK)
			else begin
				errs++;
				$display("Fail %0t: digit %h/%h with %0d seconds left", $time, act, idle, left);
			end
			k++;
			@(negedge CLOCK);
		end
		if (k >= LIMIT) begin
			timeouts++;
			$display("Timeout: phase %s never ended during countdown", p.name());
		end
	endtask

	task automatic endTest(input string name);
		$display("Test %s finished with %0d errors", name, errs - errMark);
		errMark = errs;
	endtask

	initial begin
		logic [7:0] d;
		int toggles;
		logic lastRed;
		{arstN, cyc, stb, we, adr, datW, walkButton, carSensor} = '0;
		repeat (5) @(negedge CLOCK);
		assert (i_dut.phase == trafficPkg::allRed1 && !ack && lampMaj == 3'b100
			&& lampMin == 3'b100 && dontWalkMaj && dontWalkMin && !walkMaj && !walkMin
			&& segMaj == trafficPkg::SEG_BLANK && segMin == trafficPkg::SEG_BLANK)
		else begin
			errs++;
			$display("Fail %0t: wrong state in reset", $time);
		end
		repeat (5) @(posedge CLOCK);
		#1 arstN = 1'b1;

		checkRead(trafficPkg::ADDR_CTRL, 32'd0, '1);
		for (int a = 1; a <= 4; a++) checkRead(3'(a), {24'd0, mDur[a]}, '1);
		checkRead(3'd6, 32'd0, '1);  // Unmapped
		for (int a = 1; a <= 4; a++) begin
			d = 8'(randBits(3));
			writeReg(3'(a), {24'd0, d});
			checkRead(3'(a), (d == 0) ? 32'd1 : {24'd0, d}, '1);
		end
		for (int a = 1; a <= 4; a++) writeReg(3'(a), 1 + randBits(3) % 6);
		endTest("registers");

		waitEntry(trafficPkg::majGreen);
		for (int k = 0; k < 6; k++)
			measurePhase(trafficPkg::phaseT'(k),
				durOf(trafficPkg::phaseT'(k)) * trafficPkg::TICK_CYCLES);
		endTest("timer mode");

		writeReg(trafficPkg::ADDR_CTRL, 32'd1);  // Sensor mode
		reachPhase(trafficPkg::majGreen);
		repeat (mDur[1] * trafficPkg::TICK_CYCLES + 8 + randBits(4)) begin
			@(negedge CLOCK);
			assert (i_dut.phase == trafficPkg::majGreen) else begin
				errs++;
				$display("Fail %0t: major green left with no request", $time);
			end
		end
		@(posedge CLOCK); #1;
		if (randBits(1)) walkButton = 1'b1;
		else carSensor = 1'b1;
		repeat (3) @(posedge CLOCK);
		#1 {walkButton, carSensor} = 2'b00;
		waitEntry(trafficPkg::majYellow);
		checkRead(trafficPkg::ADDR_STATUS, {28'd0, 1'b1, trafficPkg::majYellow}, 32'hF);
		waitEntry(trafficPkg::minGreen);
		checkRead(trafficPkg::ADDR_STATUS, 32'd0, 32'h8);  // Pending cleared
		writeReg(trafficPkg::ADDR_CTRL, 32'd0);
		endTest("sensor mode");

		writeReg(trafficPkg::ADDR_GREEN_MAJ, 32'd12);  // Longer than one digit
		writeReg(trafficPkg::ADDR_GREEN_MIN, 1 + randBits(3) % 6);
		waitEntry(trafficPkg::majGreen);
		countdown(trafficPkg::majGreen, 12);
		waitEntry(trafficPkg::minGreen);
		countdown(trafficPkg::minGreen, mDur[2]);
		endTest("countdown");

		writeReg(trafficPkg::ADDR_CTRL, 32'd2);
		toggles = 0;
		lastRed = 1'b1;
		repeat (40) begin
			@(negedge CLOCK);
			assert (i_dut.phase == trafficPkg::allRed1 && lampMaj == lampMin
				&& lampMaj[1:0] == 2'b00 && !walkMaj && !walkMin
				&& segMaj == trafficPkg::SEG_BLANK && segMin == trafficPkg::SEG_BLANK)
			else begin
				errs++;
				$display("Fail %0t: emergency lamps %b %b", $time, lampMaj, lampMin);
			end
			toggles += (lampMaj[2] != lastRed);
			lastRed = lampMaj[2];
		end
		assert (toggles == 40 / trafficPkg::TICK_CYCLES - 1) else begin
			errs++;
			$display("Fail %0t: reds toggled %0d times", $time, toggles);
		end
		writeReg(trafficPkg::ADDR_CTRL, 32'd0);
		@(negedge CLOCK);
		measurePhase(trafficPkg::allRed1, mDur[4] * trafficPkg::TICK_CYCLES);
		assert (i_dut.phase == trafficPkg::majGreen) else begin
			errs++;
			$display("Fail %0t: phase %0d after release", $time, i_dut.phase);
		end
		endTest("emergency");

		errs += i_dut.i_signalHeads.i_props.failCount;  // Bound lamp and phase checks
		$display("All tests done: %0d errors, %0d timeouts", errs, timeouts);
		if (errs == 0 && timeouts == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
